/* filelist.f */
src/cu_pkg.sv
src/cu_response_router.sv
src/cu_vertex_job_control.sv
src/cu_vertex_job_buffer.sv
src/cu_graph_algorithm_control.sv
src/cu_control.sv
verification/cu_control_props.sv
verification/cu_control_tb.sv

/* run.sh */
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module cu_control_tb \
	-o cu_control_sim

./obj_dir/cu_control_sim | tee sim.log

if grep -qF "*** TEST FAILED ***" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
echo "simulation finished without failure"

/* verification/cu_control_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_control_tb;

	localparam int ROW_COUNT    = 5;
	localparam int DONE_TIMEOUT = 300;
	localparam int WAIT_TIMEOUT = 50;
	localparam logic [cu_pkg::CU_ID_BITS-1:0] EDGE_ID = cu_pkg::CU_ID_BITS'(2);

	// one test case with up to 4 vertices
	typedef struct packed {
		logic [cu_pkg::CONFIG_BITS-1:0]      config_word;
		logic [2:0]                          vertex_count;
		logic [0:3][cu_pkg::VERTEX_BITS-1:0] ids;
		logic [0:3][cu_pkg::EDGE_BITS-1:0]   degrees;
		logic [cu_pkg::VERTEX_BITS-1:0]      num_vertices;
		logic [cu_pkg::EDGE_BITS-1:0]        num_edges;
		logic                                expect_done;
		logic                                foreign_edge;
	} test_row_t;

	logic                           clock = 1'b0;
	logic                           rstn;
	logic                           enabled_in;
	cu_pkg::wed_t                   wed_request;
	logic [cu_pkg::CONFIG_BITS-1:0] cu_configure;
	cu_pkg::read_data_line_t        read_data;
	logic [cu_pkg::CONFIG_BITS-1:0] cu_status;
	cu_pkg::cu_return_t             cu_return;
	logic                           cu_done;
	logic                           vertex_buffer_alfull;

	test_row_t                    rows [ROW_COUNT];
	integer                       seed;
	int                           error_count;
	int                           rows_passed;
	int                           row_errors_at_start;
	logic [cu_pkg::EDGE_BITS-1:0] edge_sum;
	logic                         done_seen;

	cu_control #(
		.BUFFER_DEPTH(8)
	) DUT (
		.clock               (clock),
		.rstn                (rstn),
		.enabled_in          (enabled_in),
		.wed_request         (wed_request),
		.cu_configure        (cu_configure),
		.read_data           (read_data),
		.cu_status           (cu_status),
		.cu_return           (cu_return),
		.cu_done             (cu_done),
		.vertex_buffer_alfull(vertex_buffer_alfull)
	);

	always #10 clock = ~clock;

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	task automatic check_value(input string what, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			$display("mismatch at %0t ns: %s is %0h, expected %0h", $time, what, got, expected);
			error_count++;
		end
	endtask

	task automatic apply_reset();
		@(posedge clock);
		rstn         <= 1'b0;
		cu_configure <= '0;
		wed_request  <= '0;
		read_data    <= '0;
		repeat (5) @(posedge clock);
		rstn <= 1'b1;
	endtask

	task automatic send_line(input logic [cu_pkg::CU_ID_BITS-1:0] id,
		input cu_pkg::data_word_u word);
		@(posedge clock);
		read_data.valid   <= 1'b1;
		read_data.cu_id   <= id;
		read_data.payload <= word;
	endtask

	task automatic send_idle();
		@(posedge clock);
		read_data.valid <= 1'b0;
	endtask

	// holds back while the job buffer is nearly full
	task automatic send_vertex(input logic [cu_pkg::VERTEX_BITS-1:0] id,
		input logic [cu_pkg::EDGE_BITS-1:0] degree);
		cu_pkg::data_word_u word;
		int                 cycles;
		cycles = 0;
		while (vertex_buffer_alfull && cycles < WAIT_TIMEOUT) begin
			send_idle();
			cycles++;
		end
		if (vertex_buffer_alfull) begin
			$display("vertex buffer stayed almost full for %0d cycles", WAIT_TIMEOUT);
			error_count++;
		end
		word.vertex_rec.vertex_id  = id;
		word.vertex_rec.out_degree = degree;
		send_line(cu_pkg::VERTEX_CONTROL_ID, word);
	endtask

	// zero-degree vertex line sent while enabled_in is low, the router drops it
	task automatic send_vertex_disabled(input logic [cu_pkg::VERTEX_BITS-1:0] id);
		cu_pkg::data_word_u word;
		word.vertex_rec.vertex_id  = id;
		word.vertex_rec.out_degree = '0;
		@(posedge clock);
		enabled_in <= 1'b0;
		send_line(cu_pkg::VERTEX_CONTROL_ID, word);
		send_idle();
		@(posedge clock);
		enabled_in <= 1'b1;
	endtask

	task automatic send_edges(input logic [cu_pkg::VERTEX_BITS-1:0] src,
		input logic [cu_pkg::EDGE_BITS-1:0] degree, input logic foreign);
		cu_pkg::data_word_u word;
		for (int e = 0; e < degree; e++) begin
			word.edge_rec.src_vertex  = src;
			word.edge_rec.dest_vertex = $random(seed);
			send_line(EDGE_ID, word);
			// an unrelated source follows the first edge and must be dropped
			if (foreign && e == 0) begin
				word.edge_rec.src_vertex = src + 32'd1000;
				send_line(EDGE_ID, word);
			end
		end
	endtask

	task automatic wait_job_enabled();
		int cycles;
		cycles = 0;
		while (!DUT.job_enabled && cycles < WAIT_TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		if (!DUT.job_enabled) begin
			$display("job enable did not come up within %0d cycles", WAIT_TIMEOUT);
			error_count++;
		end
	endtask

	task automatic wait_done(output logic seen);
		int cycles;
		cycles = 0;
		while (!cu_done && cycles < DONE_TIMEOUT) begin
			@(posedge clock);
			cycles++;
		end
		seen = cu_done;
	endtask

	//////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////

	initial begin
		rstn         <= 1'b0;
		enabled_in   <= 1'b1;
		wed_request  <= '0;
		cu_configure <= '0;
		read_data    <= '0;
		seed        = 62344;
		error_count = 0;
		rows_passed = 0;

		// plain work with all degrees nonzero
		rows[0] = '{64'h0000_0000_0000_0001, 3'd3, '{32'd10, 32'd11, 32'd12, 32'd0},
			'{32'd2, 32'd3, 32'd1, 32'd0}, 32'd3, 32'd6, 1'b1, 1'b0};
		// zero-degree vertices mixed in
		rows[1] = '{64'hA5A5_0000_0000_0003, 3'd4, '{32'd20, 32'd21, 32'd22, 32'd23},
			'{32'd0, 32'd2, 32'd0, 32'd1}, 32'd4, 32'd3, 1'b1, 1'b0};
		// foreign edges interleaved
		rows[2] = '{64'h8000_0000_0000_0000, 3'd3, '{32'd30, 32'd31, 32'd32, 32'd0},
			'{32'd3, 32'd1, 32'd2, 32'd0}, 32'd3, 32'd6, 1'b1, 1'b1};
		// every vertex filtered
		rows[3] = '{64'h0000_1234_5678_0000, 3'd4, '{32'd40, 32'd41, 32'd42, 32'd43},
			'{32'd0, 32'd0, 32'd0, 32'd0}, 32'd4, 32'd0, 1'b1, 1'b0};
		// descriptor claims more edges than exist
		rows[4] = '{64'h0000_0000_0000_0002, 3'd2, '{32'd50, 32'd51, 32'd0, 32'd0},
			'{32'd2, 32'd2, 32'd0, 32'd0}, 32'd2, 32'd7, 1'b0, 1'b1};

		for (int r = 0; r < ROW_COUNT; r++) begin
			row_errors_at_start = error_count;
			apply_reset();
			@(posedge clock);
			check_value("cu_done after reset", 64'(cu_done), 64'd0);
			check_value("cu_return after reset", cu_return, 64'd0);
			check_value("cu_status after reset", cu_status, 64'd0);
			check_value("vertex_buffer_alfull after reset", 64'(vertex_buffer_alfull), 64'd0);

			// configuration word followed by a zero word that must not overwrite it
			cu_configure <= rows[r].config_word;
			wed_request  <= '{1'b1, rows[r].num_vertices, rows[r].num_edges};
			@(posedge clock);
			cu_configure <= '0;
			wait_job_enabled();
			check_value("cu_status", cu_status, rows[r].config_word);

			// would add one filtered vertex if the router let it through
			send_vertex_disabled(32'd99);

			edge_sum = '0;
			for (int v = 0; v < int'(rows[r].vertex_count); v++) begin
				send_vertex(rows[r].ids[v], rows[r].degrees[v]);
				send_edges(rows[r].ids[v], rows[r].degrees[v], rows[r].foreign_edge);
				edge_sum += rows[r].degrees[v];
			end
			send_idle();

			wait_done(done_seen);
			if (rows[r].expect_done && !done_seen) begin
				$display("row %0d: cu_done did not rise within %0d cycles", r, DONE_TIMEOUT);
				error_count++;
			end else if (!rows[r].expect_done && done_seen) begin
				$display("row %0d: cu_done rose although edges are still missing", r);
				error_count++;
			end
			check_value("cu_return.var1", 64'(cu_return.var1), 64'(rows[r].vertex_count));
			check_value("cu_return.var2", 64'(cu_return.var2), 64'(edge_sum));

			if (error_count == row_errors_at_start) begin
				rows_passed++;
				$display("row %0d: passed", r);
			end else begin
				$display("row %0d: failed with %0d errors", r, error_count - row_errors_at_start);
			end
		end

		$display("rows %0d, passed %0d, failed %0d, errors %0d",
			ROW_COUNT, rows_passed, ROW_COUNT - rows_passed, error_count);
		if (error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verification/cu_control_props.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_control_props (
	input logic clock,
	input logic rstn,
	input logic push,
	input logic pop,
	input logic job_enabled,
	input logic cu_done
);

	// buffer occupancy rebuilt from the push and pop strobes
	logic [7:0] occupancy;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			occupancy <= '0;
		end else begin
			occupancy <= occupancy + 8'(push) - 8'(pop);
		end
	end

	// the consumer only pops a buffer that holds a job
	pop_needs_job: assert property (
		@(posedge clock) disable iff (!rstn) pop |-> (occupancy != '0)
	) else $error("pop while the vertex job buffer is empty");

	// no completion before work was enabled
	done_needs_enable: assert property (
		@(posedge clock) disable iff (!rstn) !job_enabled |-> !cu_done
	) else $error("cu_done high while job_enabled is low");

endmodule

bind cu_control cu_control_props props (
	.clock      (clock),
	.rstn       (rstn),
	.push       (push),
	.pop        (pop),
	.job_enabled(job_enabled),
	.cu_done    (cu_done)
);

`default_nettype wire

/* src/cu_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_control #(
	parameter int BUFFER_DEPTH = 8
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled_in,
	input  cu_pkg::wed_t                   wed_request,
	input  logic [cu_pkg::CONFIG_BITS-1:0] cu_configure,
	input  cu_pkg::read_data_line_t        read_data,
	output logic [cu_pkg::CONFIG_BITS-1:0] cu_status,
	output cu_pkg::cu_return_t             cu_return,
	output logic                           cu_done,
	output logic                           vertex_buffer_alfull
);

	logic enabled;
	logic cu_ready;
	logic job_enabled;

	cu_pkg::wed_t            wed_latched;
	cu_pkg::read_data_line_t vertex_data;
	cu_pkg::read_data_line_t edge_data;

	logic                push;
	cu_pkg::vertex_job_t push_job;
	cu_pkg::vertex_job_t head;
	logic                empty;
	logic                pop;

	logic [cu_pkg::VERTEX_BITS-1:0] filtered_count;
	logic [cu_pkg::VERTEX_BITS-1:0] vertex_done_count;
	logic [cu_pkg::EDGE_BITS-1:0]   edge_done_count;

	cu_pkg::cu_return_t work_count;
	cu_pkg::cu_return_t return_stage;
	logic               done_compare;

	//////////////////////////////////////////////////
	// enable chain
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled     <= 1'b0;
			job_enabled <= 1'b0;
		end else begin
			enabled     <= enabled_in;
			job_enabled <= cu_ready;
		end
	end

	// work may start once both a configuration and a descriptor are held
	assign cu_ready = (|cu_status) && wed_latched.valid;

	// a zero configuration word leaves the status untouched
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_status <= '0;
		end else if (|cu_configure) begin
			cu_status <= cu_configure;
		end
	end

	// first valid descriptor is kept until reset
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wed_latched <= '0;
		end else if (wed_request.valid && !wed_latched.valid) begin
			wed_latched <= wed_request;
		end
	end

	//////////////////////////////////////////////////
	// done and return
	//////////////////////////////////////////////////

	// stage 1 sums the counts, stage 2 compares against the descriptor
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			work_count   <= '0;
			return_stage <= '0;
			done_compare <= 1'b0;
		end else if (job_enabled) begin
			work_count.var1 <= vertex_done_count + filtered_count;
			work_count.var2 <= edge_done_count;
			return_stage    <= work_count;
			done_compare    <= (work_count.var1 == wed_latched.num_vertices) &&
				(work_count.var2 == wed_latched.num_edges);
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			cu_return <= '0;
			cu_done   <= 1'b0;
		end else begin
			cu_return <= return_stage;
			cu_done   <= done_compare;
		end
	end

	//////////////////////////////////////////////////
	// datapath
	//////////////////////////////////////////////////

	cu_response_router u_router (
		.clock      (clock),
		.rstn       (rstn),
		.enabled    (enabled),
		.read_data  (read_data),
		.vertex_data(vertex_data),
		.edge_data  (edge_data)
	);

	cu_vertex_job_control u_vertex_job_control (
		.clock         (clock),
		.rstn          (rstn),
		.enabled       (job_enabled),
		.vertex_data   (vertex_data),
		.push          (push),
		.push_job      (push_job),
		.filtered_count(filtered_count)
	);

	cu_vertex_job_buffer #(
		.BUFFER_DEPTH(BUFFER_DEPTH)
	) u_vertex_job_buffer (
		.clock   (clock),
		.rstn    (rstn),
		.push    (push),
		.pop     (pop),
		.push_job(push_job),
		.head    (head),
		.empty   (empty),
		.alfull  (vertex_buffer_alfull)
	);

	cu_graph_algorithm_control u_graph_algorithm_control (
		.clock            (clock),
		.rstn             (rstn),
		.enabled          (job_enabled),
		.head             (head),
		.empty            (empty),
		.pop              (pop),
		.edge_data        (edge_data),
		.vertex_done_count(vertex_done_count),
		.edge_done_count  (edge_done_count)
	);

endmodule

`default_nettype wire

/* src/cu_graph_algorithm_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_graph_algorithm_control (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled,
	input  cu_pkg::vertex_job_t            head,
	input  logic                           empty,
	output logic                           pop,
	input  cu_pkg::read_data_line_t        edge_data,
	output logic [cu_pkg::VERTEX_BITS-1:0] vertex_done_count,
	output logic [cu_pkg::EDGE_BITS-1:0]   edge_done_count
);

	localparam logic STATE_IDLE = 1'b0;
	localparam logic STATE_BUSY = 1'b1;

	logic                    state;
	cu_pkg::read_data_line_t edge_latched;
	cu_pkg::edge_record_t    edge_word;

	logic [cu_pkg::VERTEX_BITS-1:0] job_vertex;
	logic [cu_pkg::EDGE_BITS-1:0]   remaining;

	logic                           active;
	logic [cu_pkg::VERTEX_BITS-1:0] current_vertex;
	logic [cu_pkg::EDGE_BITS-1:0]   current_remaining;
	logic                           edge_hit;
	logic [cu_pkg::EDGE_BITS-1:0]   remaining_next;
	logic                           job_complete;

	// edge words wait a cycle so the first one meets its job at the pop
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			edge_latched <= '0;
		end else begin
			edge_latched <= edge_data;
		end
	end

	//////////////////////////////////////////////////
	// job selection
	//////////////////////////////////////////////////

	assign pop    = enabled && (state == STATE_IDLE) && !empty;
	assign active = pop || (enabled && (state == STATE_BUSY));

	// while loading, the job is still at the buffer head
	assign current_vertex    = (state == STATE_BUSY) ? job_vertex : head.vertex_id;
	assign current_remaining = (state == STATE_BUSY) ? remaining : head.out_degree;

	//////////////////////////////////////////////////
	// edge consumption
	//////////////////////////////////////////////////

	assign edge_word = edge_latched.payload.edge_rec;

	// words from another source are dropped
	assign edge_hit = active && edge_latched.valid &&
		(edge_word.src_vertex == current_vertex);

	assign remaining_next = edge_hit ? (current_remaining - 1'b1) : current_remaining;
	assign job_complete   = active && (remaining_next == '0);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state             <= STATE_IDLE;
			vertex_done_count <= '0;
			edge_done_count   <= '0;
		end else begin
			if (job_complete) begin
				state <= STATE_IDLE;
			end else if (pop) begin
				state <= STATE_BUSY;
			end
			if (edge_hit) begin
				edge_done_count <= edge_done_count + 1'b1;
			end
			if (job_complete) begin
				vertex_done_count <= vertex_done_count + 1'b1;
			end
		end
	end

	// current job, only read while busy
	always_ff @(posedge clock) begin
		if (pop) begin
			job_vertex <= head.vertex_id;
		end
		if (active) begin
			remaining <= remaining_next;
		end
	end

endmodule

`default_nettype wire

/* src/cu_vertex_job_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

// depth must be a power of two so the pointers wrap on their own
module cu_vertex_job_buffer #(
	parameter int BUFFER_DEPTH = 8
) (
	input  logic                clock,
	input  logic                rstn,
	input  logic                push,
	input  logic                pop,
	input  cu_pkg::vertex_job_t push_job,
	output cu_pkg::vertex_job_t head,
	output logic                empty,
	output logic                alfull
);

	localparam int ADDR_BITS = $clog2(BUFFER_DEPTH);
	localparam logic [ADDR_BITS:0] FULL_LEVEL   = (ADDR_BITS + 1)'(BUFFER_DEPTH);
	// two or fewer free entries
	localparam logic [ADDR_BITS:0] ALFULL_LEVEL = (ADDR_BITS + 1)'(BUFFER_DEPTH - 2);

	cu_pkg::vertex_job_t job_mem [BUFFER_DEPTH];

	logic [ADDR_BITS-1:0] wr_ptr;
	logic [ADDR_BITS-1:0] rd_ptr;
	logic [ADDR_BITS:0]   count;
	logic                 full;
	logic                 do_push;
	logic                 do_pop;

	assign full    = (count == FULL_LEVEL);
	assign empty   = (count == '0);
	assign alfull  = (count >= ALFULL_LEVEL);
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// first-word fall-through
	assign head = job_mem[rd_ptr];

	//////////////////////////////////////////////////
	// storage
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (do_push) begin
			job_mem[wr_ptr] <= push_job;
		end
	end

	//////////////////////////////////////////////////
	// pointers and occupancy
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* src/cu_vertex_job_control.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_vertex_job_control (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enabled,
	input  cu_pkg::read_data_line_t        vertex_data,
	output logic                           push,
	output cu_pkg::vertex_job_t            push_job,
	output logic [cu_pkg::VERTEX_BITS-1:0] filtered_count
);

	cu_pkg::vertex_record_t vertex_rec;
	logic                   vertex_valid;
	logic                   zero_degree;

	// every line on this side is a vertex record
	assign vertex_rec   = vertex_data.payload.vertex_rec;
	assign vertex_valid = enabled && vertex_data.valid;
	assign zero_degree  = (vertex_rec.out_degree == '0);

	//////////////////////////////////////////////////
	// push or filter
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			push           <= 1'b0;
			filtered_count <= '0;
		end else begin
			push <= vertex_valid && !zero_degree;
			// a vertex without edges is finished here and never queued
			if (vertex_valid && zero_degree) begin
				filtered_count <= filtered_count + 1'b1;
			end
		end
	end

	// job word, qualified by push
	always_ff @(posedge clock) begin
		if (vertex_valid) begin
			push_job.vertex_id  <= vertex_rec.vertex_id;
			push_job.out_degree <= vertex_rec.out_degree;
		end
	end

endmodule

`default_nettype wire

/* src/cu_response_router.sv */
`timescale 1ns/1ps
`default_nettype none

module cu_response_router (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    enabled,
	input  cu_pkg::read_data_line_t read_data,
	output cu_pkg::read_data_line_t vertex_data,
	output cu_pkg::read_data_line_t edge_data
);

	cu_pkg::read_data_line_t line_latched;
	logic                    is_vertex_line;

	//////////////////////////////////////////////////
	// input latch
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			line_latched <= '0;
		end else begin
			line_latched <= read_data;
		end
	end

	// vertex control id goes to job generation, anything else to the algorithm
	assign is_vertex_line = (line_latched.cu_id == cu_pkg::VERTEX_CONTROL_ID);

	//////////////////////////////////////////////////
	// steer
	//////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_data <= '0;
			edge_data   <= '0;
		end else begin
			// both sides see the payload, only one gets the valid
			vertex_data       <= line_latched;
			edge_data         <= line_latched;
			vertex_data.valid <= enabled && line_latched.valid && is_vertex_line;
			edge_data.valid   <= enabled && line_latched.valid && !is_vertex_line;
		end
	end

endmodule

`default_nettype wire

/* src/cu_pkg.sv */
`default_nettype none

package cu_pkg;

	//////////////////////////////////////////////////
	// widths and ids
	//////////////////////////////////////////////////

	localparam int VERTEX_BITS = 32;
	localparam int EDGE_BITS   = 32;
	localparam int CU_ID_BITS  = 8;
	localparam int CONFIG_BITS = 64;

	// read-data lines carrying this id feed vertex job generation
	localparam logic [CU_ID_BITS-1:0] VERTEX_CONTROL_ID = CU_ID_BITS'(1);

	//////////////////////////////////////////////////
	// read-data payload
	//////////////////////////////////////////////////

	typedef struct packed {
		logic [VERTEX_BITS-1:0] vertex_id;
		logic [EDGE_BITS-1:0]   out_degree;
	} vertex_record_t;

	typedef struct packed {
		logic [VERTEX_BITS-1:0] src_vertex;
		logic [VERTEX_BITS-1:0] dest_vertex;
	} edge_record_t;

	// one 64-bit word, meaning picked by the cu id of its line
	typedef union packed {
		vertex_record_t vertex_rec;
		edge_record_t   edge_rec;
	} data_word_u;

	typedef struct packed {
		logic                  valid;
		logic [CU_ID_BITS-1:0] cu_id;
		data_word_u            payload;
	} read_data_line_t;

	//////////////////////////////////////////////////
	// descriptor, jobs and return value
	//////////////////////////////////////////////////

	typedef struct packed {
		logic                   valid;
		logic [VERTEX_BITS-1:0] num_vertices;
		logic [EDGE_BITS-1:0]   num_edges;
	} wed_t;

	typedef struct packed {
		logic [VERTEX_BITS-1:0] vertex_id;
		logic [EDGE_BITS-1:0]   out_degree;
	} vertex_job_t;

	// var1 counts vertices, var2 counts edges
	typedef struct packed {
		logic [VERTEX_BITS-1:0] var1;
		logic [EDGE_BITS-1:0]   var2;
	} cu_return_t;

endpackage

`default_nettype wire
